// File: verilog/tetris_pkg.sv
// Falling-block game definitions
package tetris_pkg;

    // Board geometry, row 0 is the top row
    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;
    localparam int SPAWN_COL = 3;

    localparam int DROP_PERIOD_DEF = 16;

    // Fibonacci LFSR, taps at bits 15, 13, 12 and 10
    localparam logic [15:0] LFSR_SEED = 16'hACE1;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    localparam logic [7:0] SCORE_MAX = 8'd255;

    typedef enum logic [2:0] {
        PK_I,
        PK_O,
        PK_T,
        PK_S,
        PK_Z,
        PK_J,
        PK_L
    } piece_kind_e;

    typedef struct packed {
        piece_kind_e kind;
        logic [1:0]  rot;
    } piece_t;

    typedef enum logic [2:0] {
        MOVE_NONE,
        MOVE_LEFT,
        MOVE_RIGHT,
        MOVE_ROTATE,
        MOVE_DOWN
    } move_op_e;

    typedef struct packed {
        logic left;
        logic right;
        logic rotate;
        logic drop;
    } keys_t;

    typedef logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_t;

    typedef enum logic [2:0] {
        GS_SPAWN,
        GS_FALL,
        GS_LOCK,
        GS_CLEAR,
        GS_OVER
    } game_state_e;

    // 4x4 frame mask, bit 4*row+col set for an occupied cell
    function automatic logic [15:0] piece_shape(piece_kind_e kind, logic [1:0] rot);
        logic [15:0] cur;
        logic [15:0] nxt;
        int n;
        // I turns inside the full frame, the others inside the top-left 3x3
        n = 3;
        case (kind)
            PK_I: begin
                cur = 16'h00F0;
                n = 4;
            end
            PK_O:    cur = 16'h0066;
            PK_T:    cur = 16'h0072;
            PK_S:    cur = 16'h0036;
            PK_Z:    cur = 16'h0063;
            PK_J:    cur = 16'h0071;
            PK_L:    cur = 16'h0074;
            default: cur = '0;
        endcase
        for (int k = 0; k < 3; k++) begin
            if (k < int'(rot) && kind != PK_O) begin
                nxt = '0;
                // Clockwise turn: cell (r, c) moves to (c, n-1-r)
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        if (r < n && c < n && cur[4*r+c]) begin
                            nxt[4*c+n-1-r] = 1'b1;
                        end
                    end
                end
                cur = nxt;
            end
        end
        return cur;
    endfunction

endpackage

// File: verilog/key_strobe.sv
// Key synchronizer and move encoder
`timescale 1ns/1ps
module key_strobe (
    input  logic                 clk,
    input  logic                 reset,
    input  tetris_pkg::keys_t    keys_i,
    output tetris_pkg::move_op_e move_o
);
    import tetris_pkg::*;

    keys_t sync1_q;
    keys_t sync2_q;
    keys_t prev_q;
    keys_t rise;

    assign rise = sync2_q & ~prev_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            move_o  <= MOVE_NONE;
        end else begin
            sync1_q <= keys_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            // Rotate wins over left, right and down
            if (rise.rotate) begin
                move_o <= MOVE_ROTATE;
            end else if (rise.left) begin
                move_o <= MOVE_LEFT;
            end else if (rise.right) begin
                move_o <= MOVE_RIGHT;
            end else if (rise.drop) begin
                move_o <= MOVE_DOWN;
            end else begin
                move_o <= MOVE_NONE;
            end
        end
    end

    // An input edge three cycles back is the only source of an opcode
    assert property (@(posedge clk) disable iff (reset)
        (($past(keys_i, 3) & ~$past(keys_i, 4)) == '0) |-> (move_o == MOVE_NONE))
        else $error("move issued without a key edge");

endmodule

// File: verilog/drop_timer.sv
// Periodic drop tick generator
`timescale 1ns/1ps
module drop_timer #(
    parameter int DROP_PERIOD = tetris_pkg::DROP_PERIOD_DEF
) (
    input  logic clk,
    input  logic reset,
    input  logic run_i,
    output logic drop_tick_o
);
    localparam int CNT_W = (DROP_PERIOD > 1) ? $clog2(DROP_PERIOD) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DROP_PERIOD - 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q     <= RELOAD;
            drop_tick_o <= 1'b0;
        end else begin
            drop_tick_o <= 1'b0;
            // Count is frozen while the game is stopped
            if (run_i) begin
                if (count_q == '0) begin
                    drop_tick_o <= 1'b1;
                    count_q     <= RELOAD;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        drop_tick_o |=> !drop_tick_o [*(DROP_PERIOD-1)])
        else $error("drop ticks closer than one period");

endmodule

// File: verilog/piece_source.sv
// LFSR piece producer
`timescale 1ns/1ps
module piece_source (
    input  logic               clk,
    input  logic               reset,
    output logic               req_o,
    output tetris_pkg::piece_t piece_o,
    input  logic               ack_i
);
    import tetris_pkg::*;

    typedef enum logic {
        SRC_IDLE,
        SRC_REQ
    } src_state_e;

    src_state_e  state_q;
    logic [15:0] lfsr_q;
    logic        fb;

    assign fb = ^(lfsr_q & LFSR_TAPS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= SRC_IDLE;
            lfsr_q  <= LFSR_SEED;
        end else begin
            case (state_q)
                // Wait for the previous ack to drop before offering again
                SRC_IDLE: begin
                    if (!ack_i) begin
                        state_q <= SRC_REQ;
                    end
                end
                SRC_REQ: begin
                    if (ack_i) begin
                        state_q <= SRC_IDLE;
                        lfsr_q  <= {lfsr_q[14:0], fb};
                    end
                end
                default: state_q <= SRC_IDLE;
            endcase
        end
    end

    assign req_o = (state_q == SRC_REQ);

    // Value 7 folds back onto the I piece
    assign piece_o.kind = piece_kind_e'((lfsr_q[2:0] == 3'd7) ? 3'd0 : lfsr_q[2:0]);
    assign piece_o.rot  = lfsr_q[4:3];

    assert property (@(posedge clk) disable iff (reset) (req_o && $past(req_o)) |-> $stable(piece_o))
        else $error("piece changed while offered");

endmodule

// File: verilog/piece_queue.sv
// Two-entry piece preview queue
`timescale 1ns/1ps
module piece_queue (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_req_i,
    input  tetris_pkg::piece_t in_piece_i,
    output logic               in_ack_o,
    output logic               out_req_o,
    output tetris_pkg::piece_t out_piece_o,
    input  logic               out_ack_i,
    output tetris_pkg::piece_t next_piece_o
);
    import tetris_pkg::*;

    piece_t     mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign push = in_req_i && !in_ack_o && (count_q < 2'd2);
    assign pop  = out_req_o && out_ack_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_piece_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr_q  <= 1'b0;
            rd_ptr_q  <= 1'b0;
            count_q   <= 2'd0;
            in_ack_o  <= 1'b0;
            out_req_o <= 1'b0;
        end else begin
            // Input side, four-phase slave
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
                in_ack_o <= 1'b1;
            end else if (in_ack_o && !in_req_i) begin
                in_ack_o <= 1'b0;
            end
            // Output side, pop on the rising ack
            if (pop) begin
                rd_ptr_q  <= ~rd_ptr_q;
                out_req_o <= 1'b0;
            end else if (!out_req_o && !out_ack_i && count_q != 2'd0) begin
                out_req_o <= 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign out_piece_o  = mem_q[rd_ptr_q];
    assign next_piece_o = mem_q[~rd_ptr_q];

    assert property (@(posedge clk) disable iff (reset) count_q <= 2'd2)
        else $error("queue count above two");
    assert property (@(posedge clk) disable iff (reset) pop |-> (count_q != 2'd0))
        else $error("pop from empty queue");

endmodule

// File: verilog/game_engine.sv
// Game engine state machine
`timescale 1ns/1ps
module game_engine (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    piece_req_i,
    input  tetris_pkg::piece_t      piece_i,
    output logic                    piece_ack_o,
    input  tetris_pkg::move_op_e    move_i,
    input  logic                    drop_tick_i,
    output tetris_pkg::board_t      display_o,
    output tetris_pkg::board_t      board_o,
    output tetris_pkg::piece_kind_e active_kind_o,
    output logic                    spawn_o,
    output logic                    piece_locked_o,
    output logic                    settled_o,
    output logic                    game_over_o,
    output logic [7:0]              score_o
);
    import tetris_pkg::*;

    game_state_e       state_q;
    board_t            board_q;
    board_t            active_cells;
    board_t            shifted;
    logic signed [5:0] row_q;
    logic signed [5:0] col_q;
    logic [1:0]        rot_q;
    piece_kind_e       kind_q;
    logic [4:0]        scan_q;
    logic              tick_pend_q;
    logic              spawn_q;
    logic signed [5:0] cand_row;
    logic signed [5:0] cand_col;
    logic [1:0]        cand_rot;
    logic              lateral;
    logic              down;
    logic              cand_ok;
    logic              spawn_ok;
    logic              row_full;
    logic              any_full;
    logic              show_active;

    // True when every cell of the piece is on the board and free
    function automatic logic fits(board_t brd, logic signed [5:0] row, logic signed [5:0] col,
                                  piece_kind_e kind, logic [1:0] rot);
        logic [15:0] mask;
        logic        ok;
        int          br;
        int          bc;
        mask = piece_shape(kind, rot);
        ok = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                br = int'(row) + r;
                bc = int'(col) + c;
                if (mask[4*r+c]) begin
                    if (br < 0 || br >= BOARD_ROWS || bc < 0 || bc >= BOARD_COLS) begin
                        ok = 1'b0;
                    end else if (brd[br][bc]) begin
                        ok = 1'b0;
                    end
                end
            end
        end
        return ok;
    endfunction

    function automatic board_t place(logic signed [5:0] row, logic signed [5:0] col,
                                     piece_kind_e kind, logic [1:0] rot);
        board_t      cells;
        logic [15:0] mask;
        int          br;
        int          bc;
        cells = '0;
        mask = piece_shape(kind, rot);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                br = int'(row) + r;
                bc = int'(col) + c;
                if (mask[4*r+c] && br >= 0 && br < BOARD_ROWS && bc >= 0 && bc < BOARD_COLS) begin
                    cells[br][bc] = 1'b1;
                end
            end
        end
        return cells;
    endfunction

    // Candidate position for this cycle's command
    always_comb begin
        lateral = (move_i == MOVE_LEFT) || (move_i == MOVE_RIGHT) || (move_i == MOVE_ROTATE);
        down = !lateral && ((move_i == MOVE_DOWN) || drop_tick_i || tick_pend_q);
        cand_row = row_q;
        cand_col = col_q;
        cand_rot = rot_q;
        case (move_i)
            MOVE_LEFT:   cand_col = col_q - 6'sd1;
            MOVE_RIGHT:  cand_col = col_q + 6'sd1;
            MOVE_ROTATE: cand_rot = rot_q + 2'd1;
            default: begin
                if (down) begin
                    cand_row = row_q + 6'sd1;
                end
            end
        endcase
        cand_ok = fits(board_q, cand_row, cand_col, kind_q, cand_rot);
    end

    assign spawn_ok = fits(board_q, 6'sd0, 6'(SPAWN_COL), piece_i.kind, piece_i.rot);

    // Board with row scan_q removed and the rows above pulled down
    always_comb begin
        shifted = board_q;
        for (int r = 1; r < BOARD_ROWS; r++) begin
            if (r <= int'(scan_q)) begin
                shifted[r] = board_q[r-1];
            end
        end
        shifted[0] = '0;
        any_full = 1'b0;
        for (int r = 0; r < BOARD_ROWS; r++) begin
            if (&board_q[r]) begin
                any_full = 1'b1;
            end
        end
    end

    assign row_full = &board_q[scan_q];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= GS_SPAWN;
            board_q     <= '0;
            row_q       <= '0;
            col_q       <= 6'(SPAWN_COL);
            rot_q       <= '0;
            kind_q      <= PK_I;
            scan_q      <= 5'(BOARD_ROWS - 1);
            tick_pend_q <= 1'b0;
            spawn_q     <= 1'b0;
            piece_ack_o <= 1'b0;
            score_o     <= '0;
        end else begin
            spawn_q     <= 1'b0;
            tick_pend_q <= 1'b0;
            if (piece_ack_o && !piece_req_i) begin
                piece_ack_o <= 1'b0;
            end
            case (state_q)
                GS_SPAWN: begin
                    if (piece_req_i && !piece_ack_o) begin
                        piece_ack_o <= 1'b1;
                        spawn_q     <= 1'b1;
                        kind_q      <= piece_i.kind;
                        rot_q       <= piece_i.rot;
                        row_q       <= '0;
                        col_q       <= 6'(SPAWN_COL);
                        state_q     <= spawn_ok ? GS_FALL : GS_OVER;
                    end
                end
                GS_FALL: begin
                    // A tick that meets a sideways move is kept for the next cycle
                    tick_pend_q <= lateral && (drop_tick_i || tick_pend_q);
                    if ((lateral || down) && cand_ok) begin
                        row_q <= cand_row;
                        col_q <= cand_col;
                        rot_q <= cand_rot;
                    end else if (down) begin
                        state_q <= GS_LOCK;
                    end
                end
                GS_LOCK: begin
                    board_q <= board_q | active_cells;
                    scan_q  <= 5'(BOARD_ROWS - 1);
                    state_q <= GS_CLEAR;
                end
                GS_CLEAR: begin
                    // Full row stays under the scan so the pulled-down row is checked too
                    if (row_full) begin
                        board_q <= shifted;
                        if (score_o != SCORE_MAX) begin
                            score_o <= score_o + 8'd1;
                        end
                    end else if (scan_q == 5'd0) begin
                        state_q <= GS_SPAWN;
                    end else begin
                        scan_q <= scan_q - 5'd1;
                    end
                end
                default: state_q <= GS_OVER;
            endcase
        end
    end

    assign active_cells = place(row_q, col_q, kind_q, rot_q);
    assign show_active = (state_q == GS_FALL) || (state_q == GS_LOCK) || (state_q == GS_OVER);

    assign display_o      = show_active ? (board_q | active_cells) : board_q;
    assign board_o        = board_q;
    assign active_kind_o  = kind_q;
    assign spawn_o        = spawn_q;
    assign piece_locked_o = (state_q == GS_LOCK);
    assign settled_o      = (state_q == GS_CLEAR) && !row_full && (scan_q == 5'd0);
    assign game_over_o    = (state_q == GS_OVER);

    assert property (@(posedge clk) disable iff (reset)
        (state_q == GS_FALL) |-> ((active_cells & board_q) == '0))
        else $error("falling piece overlaps the board");
    assert property (@(posedge clk) disable iff (reset) settled_o |-> !any_full)
        else $error("full row left after clearing");

endmodule

// File: verilog/tetris_top.sv
// Falling-block game top level
`timescale 1ns/1ps
module tetris_top #(
    parameter int DROP_PERIOD = tetris_pkg::DROP_PERIOD_DEF
) (
    input  logic                    clk,
    input  logic                    reset,
    input  tetris_pkg::keys_t       keys_i,
    output tetris_pkg::board_t      display_o,
    output tetris_pkg::board_t      board_o,
    output tetris_pkg::piece_t      next_piece_o,
    output tetris_pkg::piece_kind_e active_kind_o,
    output logic                    spawn_o,
    output logic                    piece_locked_o,
    output logic                    settled_o,
    output logic                    game_over_o,
    output logic [7:0]              score_o
);
    import tetris_pkg::*;

    move_op_e move;
    logic     drop_tick;
    logic     src_req;
    logic     src_ack;
    piece_t   src_piece;
    logic     eng_req;
    logic     eng_ack;
    piece_t   eng_piece;

    key_strobe i_key_strobe (
        .clk    (clk),
        .reset  (reset),
        .keys_i (keys_i),
        .move_o (move)
    );

    drop_timer #(
        .DROP_PERIOD (DROP_PERIOD)
    ) i_drop_timer (
        .clk         (clk),
        .reset       (reset),
        .run_i       (!game_over_o),
        .drop_tick_o (drop_tick)
    );

    piece_source i_piece_source (
        .clk     (clk),
        .reset   (reset),
        .req_o   (src_req),
        .piece_o (src_piece),
        .ack_i   (src_ack)
    );

    piece_queue i_piece_queue (
        .clk          (clk),
        .reset        (reset),
        .in_req_i     (src_req),
        .in_piece_i   (src_piece),
        .in_ack_o     (src_ack),
        .out_req_o    (eng_req),
        .out_piece_o  (eng_piece),
        .out_ack_i    (eng_ack),
        .next_piece_o (next_piece_o)
    );

    game_engine i_game_engine (
        .clk            (clk),
        .reset          (reset),
        .piece_req_i    (eng_req),
        .piece_i        (eng_piece),
        .piece_ack_o    (eng_ack),
        .move_i         (move),
        .drop_tick_i    (drop_tick),
        .display_o      (display_o),
        .board_o        (board_o),
        .active_kind_o  (active_kind_o),
        .spawn_o        (spawn_o),
        .piece_locked_o (piece_locked_o),
        .settled_o      (settled_o),
        .game_over_o    (game_over_o),
        .score_o        (score_o)
    );

endmodule

// File: verif/tetris_tb.sv
// Game core testbench
`timescale 1ns/1ps
module tetris_tb;
    import tetris_pkg::*;

    localparam int DROP_PERIOD = DROP_PERIOD_DEF;
    localparam int NUM_TESTS = 5;
    // Worst piece falls the full board and then waits out a full clear scan
    localparam int PIECE_CYCLES = (BOARD_ROWS + 1) * DROP_PERIOD + 2 * BOARD_ROWS + 5;
    localparam int MAX_PIECES = 100;
    localparam int TIMEOUT_CYCLES = MAX_PIECES * PIECE_CYCLES;
    localparam int QUIET_SPAWNS = 3;
    localparam int RANDOM_PIECES = 30;

    logic        clk;
    logic        reset;
    keys_t       keys_i;
    board_t      display_o;
    board_t      board_o;
    piece_t      next_piece_o;
    piece_kind_e active_kind_o;
    logic        spawn_o;
    logic        piece_locked_o;
    logic        settled_o;
    logic        game_over_o;
    logic [7:0]  score_o;

    int          pass_cnt [NUM_TESTS];
    int          fail_cnt [NUM_TESTS];
    int          cycle_cnt = 0;
    int          spawn_cnt;
    int          settled_cnt;
    logic        first_spawn_q;
    logic        in_fall_q;
    logic [15:0] lfsr_model_q;
    logic [15:0] lfsr_next;
    logic [7:0]  exp_score_q;
    logic        rot_prev_q;
    logic [2:0]  rot_pipe_q;
    piece_kind_e exp_kind;
    piece_t      exp_next;

    tetris_top #(
        .DROP_PERIOD (DROP_PERIOD)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .keys_i         (keys_i),
        .display_o      (display_o),
        .board_o        (board_o),
        .next_piece_o   (next_piece_o),
        .active_kind_o  (active_kind_o),
        .spawn_o        (spawn_o),
        .piece_locked_o (piece_locked_o),
        .settled_o      (settled_o),
        .game_over_o    (game_over_o),
        .score_o        (score_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci step with taps 15, 13, 12 and 10, new bit into bit 0
    function automatic logic [15:0] lfsr_step(logic [15:0] value);
        return {value[14:0], value[15] ^ value[13] ^ value[12] ^ value[10]};
    endfunction

    function automatic piece_kind_e kind_from_lfsr(logic [15:0] value);
        logic [2:0] low;
        low = value[2:0];
        // Modulo 7 folds 7 onto the first kind
        if (low == 3'd7) begin
            low = 3'd0;
        end
        return piece_kind_e'(low);
    endfunction

    function automatic int full_rows(board_t b);
        int n;
        n = 0;
        for (int r = 0; r < BOARD_ROWS; r++) begin
            if (&b[r]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic logic [7:0] saturated_score(logic [7:0] score, int rows);
        int s;
        s = int'(score) + rows;
        if (s > int'(SCORE_MAX)) begin
            s = int'(SCORE_MAX);
        end
        return 8'(s);
    endfunction

    task automatic tally_pass(int id);
        pass_cnt[id]++;
    endtask

    task automatic log_failure(int id, string msg);
        fail_cnt[id]++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic report_test(int id, string name);
        $display("Test %0d %s: %0d checks passed, %0d failed",
                 id + 1, name, pass_cnt[id], fail_cnt[id]);
    endtask

    // One key held for 4 cycles, then 4 idle cycles
    task automatic press_key(int sel);
        keys_t k;
        k = '0;
        case (sel)
            0:       k.left = 1'b1;
            1:       k.right = 1'b1;
            2:       k.rotate = 1'b1;
            default: k.drop = 1'b1;
        endcase
        @(posedge clk);
        keys_i <= k;
        repeat (4) @(posedge clk);
        keys_i <= '0;
        repeat (3) @(posedge clk);
    endtask

    assign exp_kind = kind_from_lfsr(lfsr_model_q);

    // Piece that follows the one being spawned
    assign lfsr_next     = lfsr_step(lfsr_model_q);
    assign exp_next.kind = kind_from_lfsr(lfsr_next);
    assign exp_next.rot  = lfsr_next[4:3];

    // Reference state tracked from the DUT's event strobes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            first_spawn_q <= 1'b0;
            in_fall_q     <= 1'b0;
            lfsr_model_q  <= LFSR_SEED;
            exp_score_q   <= '0;
            rot_prev_q    <= 1'b0;
            rot_pipe_q    <= '0;
            spawn_cnt     <= 0;
            settled_cnt   <= 0;
        end else begin
            // Rotate edge reaches the engine 3 cycles after the key goes high
            rot_prev_q <= keys_i.rotate;
            rot_pipe_q <= {rot_pipe_q[1:0], keys_i.rotate & ~rot_prev_q};
            if (spawn_o) begin
                first_spawn_q <= 1'b1;
                lfsr_model_q  <= lfsr_step(lfsr_model_q);
                spawn_cnt     <= spawn_cnt + 1;
            end
            if (spawn_o && !game_over_o) begin
                in_fall_q <= 1'b1;
            end else if (piece_locked_o) begin
                in_fall_q <= 1'b0;
            end
            // Display during lock is the board with the piece merged in
            if (piece_locked_o) begin
                exp_score_q <= saturated_score(score_o, full_rows(display_o));
            end
            if (settled_o) begin
                settled_cnt <= settled_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (reset) (!first_spawn_q && !spawn_o) |->
        (display_o == '0 && board_o == '0 && score_o == 8'd0 && !game_over_o))
        tally_pass(0);
    else log_failure(0, "board, score or game over not clear before the first spawn");

    assert property (@(posedge clk) disable iff (reset) spawn_o |-> (active_kind_o == exp_kind))
        tally_pass(1);
    else log_failure(1, $sformatf("spawned kind %0d, expected %0d",
                                  $sampled(active_kind_o), $sampled(exp_kind)));

    // From the second spawn on the queue is full and previews the following piece
    assert property (@(posedge clk) disable iff (reset)
        (spawn_o && spawn_cnt > 0) |-> (next_piece_o == exp_next))
        tally_pass(1);
    else log_failure(1, $sformatf("preview piece %0h, expected %0h",
                                  $sampled(next_piece_o), $sampled(exp_next)));

    assert property (@(posedge clk) disable iff (reset)
        in_fall_q |-> ($countones(display_o) == $countones(board_o) + 4))
        tally_pass(2);
    else log_failure(2, "display does not hold exactly four cells more than the board");

    assert property (@(posedge clk) disable iff (reset)
        (rot_pipe_q[2] && in_fall_q && !piece_locked_o && !game_over_o &&
         active_kind_o == PK_O) |=> $stable(display_o))
        tally_pass(2);
    else log_failure(2, "rotating the O piece changed the display");

    assert property (@(posedge clk) disable iff (reset) settled_o |-> (full_rows(board_o) == 0))
        tally_pass(3);
    else log_failure(3, "full row left on the board after clearing");

    assert property (@(posedge clk) disable iff (reset) settled_o |-> (score_o == exp_score_q))
        tally_pass(3);
    else log_failure(3, $sformatf("score %0d, expected %0d",
                                  $sampled(score_o), $sampled(exp_score_q)));

    assert property (@(posedge clk) disable iff (reset)
        game_over_o |=> (game_over_o && !spawn_o && $stable(display_o)))
        tally_pass(4);
    else log_failure(4, "activity after game over");

    initial begin
        int sel;
        int tot_pass;
        int tot_fail;
        for (int i = 0; i < NUM_TESTS; i++) begin
            pass_cnt[i] = 0;
            fail_cnt[i] = 0;
        end
        reset = 1'b1;
        keys_i = '0;
        sel = $urandom(32'h565a);
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        while (spawn_cnt == 0) @(posedge clk);
        report_test(0, "reset state");

        // No keys, so the queue fills while pieces fall straight down
        while (spawn_cnt < QUIET_SPAWNS) @(posedge clk);
        report_test(1, "piece order");

        while (!game_over_o && settled_cnt < RANDOM_PIECES) begin
            sel = int'($urandom % 4);
            press_key(sel);
        end
        report_test(2, "cell count");
        report_test(3, "line clearing and score");

        // Pieces pile up at the spawn column until one no longer fits
        while (!game_over_o) @(posedge clk);
        repeat (4 * DROP_PERIOD) @(posedge clk);
        report_test(4, "game over");

        tot_pass = 0;
        tot_fail = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            tot_pass += pass_cnt[i];
            tot_fail += fail_cnt[i];
        end
        $display("Checks passed: %0d, failed: %0d", tot_pass, tot_fail);
        if (tot_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/tetris_pkg.sv
verilog/key_strobe.sv
verilog/drop_timer.sv
verilog/piece_source.sv
verilog/piece_queue.sv
verilog/game_engine.sv
verilog/tetris_top.sv
verif/tetris_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tetris_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
